// File: src/piano_pkg.sv
`default_nettype none

package piano_pkg;

    localparam int NUM_KEYS     = 21;
    localparam int KEYS_PER_ROW = 7;

    typedef logic [9:0]          coord_t;    // pixel / counter position
    typedef logic [11:0]         rgb_t;      // 4:4:4
    typedef logic [4:0]          key_idx_t;
    typedef logic [NUM_KEYS-1:0] key_mask_t; // bit i is key i

    // 640x480 @ 60 Hz
    localparam coord_t H_ACTIVE = 10'd640;
    localparam coord_t H_FRONT  = 10'd16;
    localparam coord_t H_SYNC   = 10'd96;
    localparam coord_t H_TOTAL  = 10'd800;
    localparam coord_t V_ACTIVE = 10'd480;
    localparam coord_t V_FRONT  = 10'd10;
    localparam coord_t V_SYNC   = 10'd2;
    localparam coord_t V_TOTAL  = 10'd525;

    // key geometry
    localparam coord_t KEY_W      = 10'd45;
    localparam coord_t KEY_H      = 10'd40;
    localparam coord_t KEY_PITCH  = 10'd55;
    localparam coord_t KEY_RADIUS = 10'd5;

    // top left corner of the first key in each row
    localparam coord_t ROW0_X = 10'd80;
    localparam coord_t ROW1_X = 10'd110;
    localparam coord_t ROW2_X = 10'd120;
    localparam coord_t ROW0_Y = 10'd120;
    localparam coord_t ROW1_Y = 10'd180;
    localparam coord_t ROW2_Y = 10'd240;

    localparam rgb_t COLOR_BLACK = 12'h000;
    localparam rgb_t COLOR_WHITE = 12'hfff;
    localparam rgb_t COLOR_GREY  = 12'h888;

endpackage

`default_nettype wire

// File: src/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing
    import piano_pkg::*;
(
    input  logic   vga_clk,
    input  logic   rst,
    output coord_t pix_x,
    output coord_t pix_y,
    output logic   active,
    output logic   hsync_raw,
    output logic   vsync_raw
);

    logic h_last;
    logic v_last;

    assign h_last = (pix_x == H_TOTAL - 10'd1);
    assign v_last = (pix_y == V_TOTAL - 10'd1);

    always_ff @(posedge vga_clk or negedge rst) begin
        if (!rst) begin
            pix_x <= '0;
        end else if (h_last) begin
            pix_x <= '0;
        end else begin
            pix_x <= pix_x + 10'd1;
        end
    end

    // line counter steps once per wrap of pix_x
    always_ff @(posedge vga_clk or negedge rst) begin
        if (!rst) begin
            pix_y <= '0;
        end else if (h_last) begin
            if (v_last) begin
                pix_y <= '0;
            end else begin
                pix_y <= pix_y + 10'd1;
            end
        end
    end

    assign active = (pix_x < H_ACTIVE) && (pix_y < V_ACTIVE);

    // both syncs are active low
    assign hsync_raw = !((pix_x >= H_ACTIVE + H_FRONT) &&
                         (pix_x <  H_ACTIVE + H_FRONT + H_SYNC));
    assign vsync_raw = !((pix_y >= V_ACTIVE + V_FRONT) &&
                         (pix_y <  V_ACTIVE + V_FRONT + V_SYNC));

    a_scan_in_range: assert property (
        @(posedge vga_clk) disable iff (!rst)
        (pix_x < H_TOTAL) && (pix_y < V_TOTAL)
    ) else $error("scan counters out of range x=%0d y=%0d", pix_x, pix_y);

endmodule

`default_nettype wire

// File: src/key_locator.sv
`timescale 1ns/1ps
`default_nettype none

module key_locator
    import piano_pkg::*;
(
    input  coord_t   pix_x,
    input  coord_t   pix_y,
    output logic     key_hit,
    output key_idx_t key_idx
);

    logic     in_row;
    coord_t   row_x;
    coord_t   row_y;
    key_idx_t row_base;
    coord_t   dx;
    coord_t   dy;
    coord_t   col;
    coord_t   rem;
    logic     in_left;
    logic     in_right;
    logic     in_top;
    logic     in_bot;
    coord_t   corner_dx;
    coord_t   corner_dy;
    coord_t   dist_sq;
    logic     corner_ok;

    // row select from the vertical position
    always_comb begin
        in_row   = 1'b1;
        row_x    = ROW0_X;
        row_y    = ROW0_Y;
        row_base = 5'd0;
        if (pix_y >= ROW0_Y && pix_y < ROW0_Y + KEY_H) begin
            row_x    = ROW0_X;
            row_y    = ROW0_Y;
            row_base = 5'd0;
        end else if (pix_y >= ROW1_Y && pix_y < ROW1_Y + KEY_H) begin
            row_x    = ROW1_X;
            row_y    = ROW1_Y;
            row_base = 5'd7;
        end else if (pix_y >= ROW2_Y && pix_y < ROW2_Y + KEY_H) begin
            row_x    = ROW2_X;
            row_y    = ROW2_Y;
            row_base = 5'd14;
        end else begin
            in_row = 1'b0;
        end
    end

    assign dx  = pix_x - row_x;
    assign dy  = pix_y - row_y;
    assign col = dx / KEY_PITCH;
    assign rem = dx % KEY_PITCH;    // position inside the key cell

    assign in_left  = (rem < KEY_RADIUS);
    assign in_right = (rem >= KEY_W - KEY_RADIUS);
    assign in_top   = (dy < KEY_RADIUS);
    assign in_bot   = (dy >= KEY_H - KEY_RADIUS);

    // offsets from the inner corner point of the corner square
    assign corner_dx = in_left ? (KEY_RADIUS - rem) : (rem - (KEY_W - KEY_RADIUS));
    assign corner_dy = in_top  ? (KEY_RADIUS - dy)  : (dy - (KEY_H - KEY_RADIUS));
    assign dist_sq   = corner_dx * corner_dx + corner_dy * corner_dy;

    assign corner_ok = !((in_left || in_right) && (in_top || in_bot)) ||
                       (dist_sq < KEY_RADIUS * KEY_RADIUS);

    assign key_hit = in_row && (pix_x >= row_x) && (col < coord_t'(KEYS_PER_ROW)) &&
                     (rem < KEY_W) && corner_ok;
    assign key_idx = row_base + key_idx_t'(col);

    always_comb begin
        if (key_hit) begin
            a_idx_in_range: assert (key_idx < NUM_KEYS)
                else $error("key index %0d out of range", key_idx);
        end
    end

endmodule

`default_nettype wire

// File: src/key_shade_reg.sv
`timescale 1ns/1ps
`default_nettype none

module key_shade_reg
    import piano_pkg::*;
(
    input  logic      vga_clk,
    input  logic      rst,
    input  key_mask_t key_table,
    output key_mask_t pressed
);

    logic table_empty;

    assign table_empty = (key_table == '0);

    // keys stay shaded until the table reads all zero
    always_ff @(posedge vga_clk or negedge rst) begin
        if (!rst) begin
            pressed <= '0;
        end else if (table_empty) begin
            pressed <= '0;
        end else begin
            pressed <= pressed | key_table;
        end
    end

endmodule

`default_nettype wire

// File: src/pixel_out.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_out
    import piano_pkg::*;
(
    input  logic      vga_clk,
    input  logic      rst,
    input  logic      active,
    input  logic      hsync_raw,
    input  logic      vsync_raw,
    input  logic      key_hit,
    input  key_idx_t  key_idx,
    input  key_mask_t pressed,
    output logic      hsync,
    output logic      vsync,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue
);

    rgb_t colour;
    logic active_q;

    always_comb begin
        if (!active || !key_hit) begin
            colour = COLOR_BLACK;     // blanking, gaps, top band
        end else if (pressed[key_idx]) begin
            colour = COLOR_GREY;
        end else begin
            colour = COLOR_WHITE;
        end
    end

    // colour and syncs leave together one cycle behind the counters
    always_ff @(posedge vga_clk or negedge rst) begin
        if (!rst) begin
            hsync              <= 1'b1;
            vsync              <= 1'b1;
            active_q           <= 1'b0;
            {red, green, blue} <= COLOR_BLACK;
        end else begin
            hsync              <= hsync_raw;
            vsync              <= vsync_raw;
            active_q           <= active;
            {red, green, blue} <= colour;
        end
    end

    a_black_in_blank: assert property (
        @(posedge vga_clk) disable iff (!rst)
        !active_q |-> ({red, green, blue} == COLOR_BLACK)
    ) else $error("colour not black during blanking");

endmodule

`default_nettype wire

// File: src/piano_vga_top.sv
`timescale 1ns/1ps
`default_nettype none

module piano_vga_top
    import piano_pkg::*;
(
    input  logic       vga_clk,
    input  logic       rst,
    input  key_mask_t  key_table,
    output logic       hsync,
    output logic       vsync,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue
);

    coord_t    pix_x;
    coord_t    pix_y;
    logic      active;
    logic      hsync_raw;
    logic      vsync_raw;
    logic      key_hit;
    key_idx_t  key_idx;
    key_mask_t pressed;

    vga_timing i_vga_timing (
        .vga_clk   (vga_clk),
        .rst       (rst),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .active    (active),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw)
    );

    key_locator i_key_locator (
        .pix_x   (pix_x),
        .pix_y   (pix_y),
        .key_hit (key_hit),
        .key_idx (key_idx)
    );

    key_shade_reg i_key_shade_reg (
        .vga_clk   (vga_clk),
        .rst       (rst),
        .key_table (key_table),
        .pressed   (pressed)
    );

    pixel_out i_pixel_out (
        .vga_clk   (vga_clk),
        .rst       (rst),
        .active    (active),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw),
        .key_hit   (key_hit),
        .key_idx   (key_idx),
        .pressed   (pressed),
        .hsync     (hsync),
        .vsync     (vsync),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

endmodule

`default_nettype wire

// File: tests/tb_piano_vga.sv
`timescale 1ns/1ps
`default_nettype none

module tb_piano_vga
    import piano_pkg::*;
();

    localparam int TIMEOUT      = 2 * 800 * 525;
    localparam int FRAME_CYCLES = 800 * 525;
    localparam int LIT_PIXELS   = 21 * 1769;  // 1800 per key less 31 cut by the corners

    logic       vga_clk;
    logic       rst;
    key_mask_t  key_table;
    logic       hsync;
    logic       vsync;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;

    int          n_pass;
    int          n_fail;
    int          test_errs;
    logic [15:0] lfsr;

    piano_vga_top i_piano_vga_top (
        .vga_clk   (vga_clk),
        .rst       (rst),
        .key_table (key_table),
        .hsync     (hsync),
        .vsync     (vsync),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

    initial begin
        vga_clk = 1'b0;
        forever #2 vga_clk = ~vga_clk;
    end

    // galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic key_mask_t random_mask();
        key_mask_t m;
        for (int i = 0; i < NUM_KEYS; i++) begin
            lfsr = lfsr_step(lfsr);
            m[i] = lfsr[0];
        end
        if (m == '0) m[0] = 1'b1;  // a press needs at least one key
        return m;
    endfunction

    // colour of screen pixel (x, y) worked out from the key layout
    function automatic rgb_t expect_colour(input int x, input int y, input key_mask_t shade);
        int   left;
        int   top;
        int   lx;
        int   ly;
        int   cx;
        int   cy;
        int   r;
        logic corner;
        rgb_t c;
        c = COLOR_BLACK;
        r = int'(KEY_RADIUS);
        for (int k = 0; k < NUM_KEYS; k++) begin
            left = (k < KEYS_PER_ROW) ? int'(ROW0_X) :
                   (k < 2 * KEYS_PER_ROW) ? int'(ROW1_X) : int'(ROW2_X);
            top  = (k < KEYS_PER_ROW) ? int'(ROW0_Y) :
                   (k < 2 * KEYS_PER_ROW) ? int'(ROW1_Y) : int'(ROW2_Y);
            lx = x - left - (k % KEYS_PER_ROW) * int'(KEY_PITCH);
            ly = y - top;
            cx = (lx < r) ? r - lx : lx - (int'(KEY_W) - r);
            cy = (ly < r) ? r - ly : ly - (int'(KEY_H) - r);
            corner = (lx < r || lx >= int'(KEY_W) - r) && (ly < r || ly >= int'(KEY_H) - r);
            if (lx >= 0 && lx < int'(KEY_W) && ly >= 0 && ly < int'(KEY_H) &&
                (!corner || cx * cx + cy * cy < r * r)) begin
                c = shade[k] ? COLOR_GREY : COLOR_WHITE;
            end
        end
        if (x >= int'(H_ACTIVE) || y >= int'(V_ACTIVE)) c = COLOR_BLACK;
        return c;
    endfunction

    task automatic check_value(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        assert (got === want) else begin
            $display("ERROR %s expected %0d actual %0d", name, want, got);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic finish_run();
        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    // counts cycles until the chosen sync reads the given level
    task automatic wait_for_sync(input logic use_v, input logic level, output int cycles);
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge vga_clk);
            cycles++;
            seen = ((use_v ? vsync : hsync) === level);
        end
        if (!seen) begin
            $display("timed out after %0d cycles waiting for %s to read %0b",
                     cycles, use_v ? "vsync" : "hsync", level);
            n_fail++;
            finish_run();
        end
    endtask

    // every pixel of one full screen from the vsync falling edge
    task automatic check_frame(input string name, input key_mask_t table_in,
                               input key_mask_t shade);
        int          c;
        int          x;
        int          y;
        int          lit;
        int          bad;
        logic [13:0] want;  // hsync, vsync, colour
        logic [13:0] got;
        lit = 0;
        bad = 0;
        wait_for_sync(1'b1, 1'b1, c);
        wait_for_sync(1'b1, 1'b0, c);  // output now shows (0, 490)
        for (int n = 1; n < FRAME_CYCLES; n++) begin
            @(posedge vga_clk);
            if (n == 1) key_table <= table_in;  // still in vertical blanking
            @(negedge vga_clk);
            x    = n % 800;
            y    = (490 + n / 800) % 525;
            want = {(x < 656 || x >= 752), (y < 490 || y >= 492),
                    expect_colour(x, y, shade)};
            got  = {hsync, vsync, red, green, blue};
            if (got[11:0] != COLOR_BLACK) lit++;
            assert (got === want) else begin
                if (bad < 4) begin
                    $display("ERROR %s pixel (%0d,%0d) expected %h actual %h",
                             name, x, y, want, got);
                end
                bad++;
            end
        end
        test_errs += bad;
        check_value({name, " lit pixels"}, LIT_PIXELS, lit);
    endtask

    task automatic test_reset();
        repeat (4) @(posedge vga_clk);
        @(negedge vga_clk);
        check_value("reset hsync", 1, hsync);
        check_value("reset vsync", 1, vsync);
        check_value("reset colour", COLOR_BLACK, {red, green, blue});
        @(posedge vga_clk);
        rst <= 1'b1;
        repeat (2) begin
            @(negedge vga_clk);
            check_value("first cycle hsync", 1, hsync);
            check_value("first cycle vsync", 1, vsync);
            check_value("first cycle colour", COLOR_BLACK, {red, green, blue});
        end
        end_test("reset");
    endtask

    task automatic test_sync_timing();
        int c;
        int low;
        int high;
        wait_for_sync(1'b0, 1'b1, c);
        wait_for_sync(1'b0, 1'b0, c);
        wait_for_sync(1'b0, 1'b1, low);
        wait_for_sync(1'b0, 1'b0, high);
        check_value("hsync low width", 96, low);
        check_value("hsync period", 800, low + high);
        wait_for_sync(1'b1, 1'b1, c);
        wait_for_sync(1'b1, 1'b0, c);
        wait_for_sync(1'b1, 1'b1, low);
        wait_for_sync(1'b1, 1'b0, high);
        check_value("vsync low width", 1600, low);
        check_value("vsync period", 420000, low + high);
        end_test("sync timing");
    endtask

    task automatic test_idle_frame();
        check_frame("idle frame", '0, '0);
        end_test("idle frame");
    endtask

    task automatic test_press_sticky_clear();
        key_mask_t m1;
        key_mask_t m2;
        m1 = random_mask();
        m2 = random_mask();
        check_frame("press", m1, m1);
        end_test("press");
        check_frame("sticky", m2, m1 | m2);  // first mask stays shaded
        end_test("sticky");
        check_frame("clear", '0, '0);
        end_test("clear");
    endtask

    initial begin
        rst       = 1'b0;
        key_table = '0;
        lfsr      = 16'd83;
        n_pass    = 0;
        n_fail    = 0;
        test_errs = 0;
        test_reset();
        test_sync_timing();
        test_idle_frame();
        test_press_sticky_clear();
        finish_run();
    end

endmodule

`default_nettype wire

// File: piano_vga.f
src/piano_pkg.sv
src/vga_timing.sv
src/key_locator.sv
src/key_shade_reg.sv
src/pixel_out.sv
src/piano_vga_top.sv
tests/tb_piano_vga.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_piano_vga
FILELIST  ?= piano_vga.f
BUILD_DIR ?= obj_dir
PASS_MSG  := Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
